// ==== project.f ====
+incdir+logic
+incdir+verif
logic/fp_pkg.sv
logic/fp_unpack.sv
logic/fp_align.sv
logic/fp_mant_addsub.sv
logic/fp_normalize.sv
logic/fp_add64.sv
verif/fp_add64_tb.sv

// ==== Makefile ====
# verilator flow for the fp_add64 double precision adder

TB  = fp_add64_tb
RTL = fp_add64

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wno-fatal -f project.f --top-module $(RTL)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	  -f project.f --top-module $(TB) -o $(TB)
	./obj_dir/$(TB) 2>&1 | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== verif/fp_add_model.svh ====
//----------------------------------------------------------
// reference model of the double precision adder
// bit-level rules of alignment, add/sub and normalization
//----------------------------------------------------------
`ifndef FP_ADD_MODEL_SVH
`define FP_ADD_MODEL_SVH

// hidden one only for a non-zero exponent field
function automatic logic [52:0] sig_with_hidden(input logic [63:0] x);
  return {(x[62:52] != 11'd0), x[51:0]};
endfunction

// right shift by amt, bits may fall 52 places below the lsb
// and are lost past that
function automatic logic [52:0] shift_round(input logic [52:0] sig, input int amt);
  logic [52:0] kept;
  logic        guard;
  logic        rnd;
  logic        sticky;
  int          pos;
  kept   = '0;
  guard  = 1'b0;
  rnd    = 1'b0;
  sticky = 1'b0;
  for (int j = 0; j < 53; j++) begin
    // landing place of bit j, counted from the bottom of the extension
    pos = j + 52 - amt;
    if (sig[j] && pos >= 52) begin
      kept[pos-52] = 1'b1;
    end else if (sig[j] && pos == 51) begin
      guard = 1'b1;
    end else if (sig[j] && pos == 50) begin
      rnd = 1'b1;
    end else if (sig[j] && pos >= 0) begin
      sticky = 1'b1;
    end
  end
  if (guard && (rnd || sticky || kept[0])) begin
    kept = kept + 53'd1;
  end
  return kept;
endfunction

function automatic logic [63:0] model_add(input logic [63:0] a, input logic [63:0] b);
  logic [52:0] sa;
  logic [52:0] sb;
  logic [10:0] exp;
  logic [53:0] mag;
  logic        sign;
  int          diff;
  int          lead;
  sa   = sig_with_hidden(a);
  sb   = sig_with_hidden(b);
  diff = int'(a[62:52]) - int'(b[62:52]);
  if (diff >= 0) begin
    exp = a[62:52];
    sb  = shift_round(sb, diff);
  end else begin
    exp = b[62:52];
    sa  = shift_round(sa, -diff);
  end
  // a wins the sign only when strictly bigger
  sign = (sa > sb) ? a[63] : b[63];
  if (a[63] == b[63]) begin
    mag = {1'b0, sa} + {1'b0, sb};
  end else if (sa >= sb) begin
    mag = {1'b0, sa} - {1'b0, sb};
  end else begin
    mag = {1'b0, sb} - {1'b0, sa};
  end
  // exact cancellation
  if (a[63] != b[63] && mag == 54'd0) begin
    return 64'd0;
  end
  if (mag[53]) begin
    mag = (mag >> 1) + {53'd0, mag[1] & mag[0]};
    exp = exp + 11'd1;
  end
  if (!mag[52] && mag != 54'd0) begin
    lead = 51;
    while (!mag[lead]) begin
      lead--;
    end
    mag = mag << (52 - lead);
    exp = exp - 11'(52 - lead);
  end
  return {sign, exp, mag[51:0]};
endfunction

`endif

// ==== verif/fp_add64_tb.sv ====
//----------------------------------------------------------
// fp_add64 testbench
// random operand pairs from a fixed seed, results checked
// in order against a reference model through a queue
//----------------------------------------------------------
`include "fp_defs.svh"

module fp_add64_tb import fp_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // about 2200 stimulus cycles plus reset and flush
  localparam int MAX_CYCLES = 3000;

  logic    clk = 1'b0;
  logic    rstn;
  fp_num_t num_a;
  fp_num_t num_b;
  logic    in_valid;
  fp_num_t result;
  logic    result_valid;

  integer seed;
  int     cycle_cnt;
  int     neg_cnt;
  int     first_in;
  int     first_out;
  int     mismatch_cnt;
  int     other_cnt;
  int     checked_cnt;
  logic [`FP_PIPE_DEPTH-1:0] vld_hist;
  logic [63:0] exp_val;
  string       exp_name;

  // expected results in issue order
  logic [63:0] exp_q[$];
  string       name_q[$];

  `include "fp_add_model.svh"

  fp_add64 fp_add64_i (
    .clk          (clk),
    .rstn         (rstn),
    .num_a        (num_a),
    .num_b        (num_b),
    .in_valid     (in_valid),
    .result       (result),
    .result_valid (result_valid)
  );

  always #20 clk = ~clk;

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'({$random(seed)} % (hi - lo + 1));
  endfunction

  function automatic logic [63:0] rand_operand(input logic s, input int e);
    logic [63:0] frac;
    frac = {$random(seed), $random(seed)};
    return {s, 11'(e), frac[51:0]};
  endfunction

  task automatic maybe_swap(inout logic [63:0] a, inout logic [63:0] b);
    logic [63:0] t;
    if (rand_range(0, 1) == 1) begin
      t = a;
      a = b;
      b = t;
    end
  endtask

  task automatic send_pair(input logic [63:0] a, input logic [63:0] b,
                           input logic [63:0] expected, input string name);
    @(posedge clk);
    num_a    <= a;
    num_b    <= b;
    in_valid <= 1'b1;
    exp_q.push_back(expected);
    name_q.push_back(name);
  endtask

  // payload keeps moving with the strobe low
  task automatic idle_cycle();
    @(posedge clk);
    in_valid <= 1'b0;
    num_a    <= rand_operand(1'b0, rand_range(100, 1900));
    num_b    <= rand_operand(1'b1, rand_range(100, 1900));
  endtask

  function automatic void print_summary();
    $display("summary: checked=%0d mismatches=%0d other_errors=%0d",
             checked_cnt, mismatch_cnt, other_cnt);
  endfunction

  // outputs sampled on the falling edge, away from the drive edge
  always @(negedge clk) begin
    if (rstn) begin
      neg_cnt++;
      if (in_valid && first_in < 0) begin
        first_in = neg_cnt;
      end
      if (result_valid && first_out < 0) begin
        first_out = neg_cnt;
      end
      // strobe pattern delayed by the pipeline depth
      assert (result_valid == vld_hist[`FP_PIPE_DEPTH-1]) else begin
        $display("MISMATCH test=valid_timing expected=%0b actual=%0b",
                 vld_hist[`FP_PIPE_DEPTH-1], result_valid);
        mismatch_cnt++;
      end
      vld_hist = {vld_hist[`FP_PIPE_DEPTH-2:0], in_valid};
      if (result_valid) begin
        assert (exp_q.size() > 0) else begin
          $display("error: result_valid high with no result outstanding at %0t", $time);
          other_cnt++;
        end
        if (exp_q.size() > 0) begin
          exp_val  = exp_q.pop_front();
          exp_name = name_q.pop_front();
          checked_cnt++;
          assert (result == exp_val) else begin
            $display("MISMATCH test=%s expected=%h actual=%h", exp_name, exp_val, result);
            mismatch_cnt++;
          end
        end
      end
    end
  end

  // run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("error: timeout after %0d cycles with %0d results outstanding",
             cycle_cnt, exp_q.size());
    other_cnt++;
    print_summary();
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [63:0] a;
    logic [63:0] b;
    logic        s;
    int          base;
    int          d;
    rstn         = 1'b0;
    num_a        = '0;
    num_b        = '0;
    in_valid     = 1'b0;
    seed         = 23;
    neg_cnt      = 0;
    first_in     = -1;
    first_out    = -1;
    mismatch_cnt = 0;
    other_cnt    = 0;
    checked_cnt  = 0;
    vld_hist     = '0;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    // quiet cycles, result_valid must stay low
    repeat (3) idle_cycle();
    // same sign, carry and alignment rounding
    for (int i = 0; i < 600; i++) begin
      s    = 1'(rand_range(0, 1));
      d    = rand_range(0, 60);
      base = rand_range(100, 1840);
      a    = rand_operand(s, base + d);
      b    = rand_operand(s, base);
      maybe_swap(a, b);
      send_pair(a, b, model_add(a, b), "same_sign");
    end
    // opposite sign, close exponents
    for (int i = 0; i < 600; i++) begin
      s    = 1'(rand_range(0, 1));
      d    = rand_range(0, 3);
      base = rand_range(100, 1897);
      a    = rand_operand(s, base + d);
      b    = rand_operand(!s, base);
      maybe_swap(a, b);
      send_pair(a, b, model_add(a, b), "opposite_sign");
    end
    // x plus -x is +0
    for (int i = 0; i < 100; i++) begin
      a = rand_operand(1'(rand_range(0, 1)), rand_range(100, 1900));
      b = {~a[63], a[62:0]};
      send_pair(a, b, 64'd0, "cancel");
    end
    // smaller operand vanishes, a holds the larger one
    for (int i = 0; i < 100; i++) begin
      d    = rand_range(55, 300);
      base = rand_range(100, 1600);
      a    = rand_operand(1'(rand_range(0, 1)), base + d);
      b    = rand_operand(1'(rand_range(0, 1)), base);
      if (rand_range(0, 1) == 1) begin
        send_pair(b, a, a, "large_diff");
      end else begin
        send_pair(a, b, a, "large_diff");
      end
    end
    // gaps in the strobe, about one idle per three valid
    for (int i = 0; i < 500; i++) begin
      while (rand_range(0, 3) == 0) begin
        idle_cycle();
      end
      d    = rand_range(0, 60);
      base = rand_range(100, 1840);
      a    = rand_operand(1'(rand_range(0, 1)), base + d);
      b    = rand_operand(1'(rand_range(0, 1)), base);
      maybe_swap(a, b);
      send_pair(a, b, model_add(a, b), "stream");
    end
    idle_cycle();
    // last result is due one pipeline depth after its sample
    repeat (`FP_PIPE_DEPTH + 2) @(posedge clk);
    assert (exp_q.size() == 0) else begin
      $display("error: %0d expected results never came out", exp_q.size());
      other_cnt++;
    end
    assert (first_out - first_in == `FP_PIPE_DEPTH) else begin
      $display("MISMATCH test=first_latency expected=%0d actual=%0d",
               `FP_PIPE_DEPTH, first_out - first_in);
      mismatch_cnt++;
    end
    print_summary();
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/fp_add64.sv ====
//----------------------------------------------------------
// fp_add64
// eight-stage double precision adder, chains unpack, align,
// add/sub and normalize blocks under valid strobes
//----------------------------------------------------------
`include "fp_defs.svh"

module fp_add64 import fp_pkg::*; (
  input  logic    clk,
  input  logic    rstn,
  input  fp_num_t num_a,
  input  fp_num_t num_b,
  input  logic    in_valid,
  output fp_num_t result,
  output logic    result_valid
);

  // inter-stage payloads and their valid bits
  fp_unp_t     unp;
  logic        unp_valid;
  fp_aligned_t aln;
  logic        aln_valid;
  fp_sum_t     sum;
  logic        sum_valid;

  // stages 1-2
  fp_unpack fp_unpack_i (
    .clk       (clk),
    .rstn      (rstn),
    .num_a     (num_a),
    .num_b     (num_b),
    .in_valid  (in_valid),
    .unp       (unp),
    .unp_valid (unp_valid)
  );

  // stage 3
  fp_align fp_align_i (
    .clk       (clk),
    .rstn      (rstn),
    .unp       (unp),
    .unp_valid (unp_valid),
    .aln       (aln),
    .aln_valid (aln_valid)
  );

  // stages 4-6
  fp_mant_addsub fp_mant_addsub_i (
    .clk       (clk),
    .rstn      (rstn),
    .aln       (aln),
    .aln_valid (aln_valid),
    .sum       (sum),
    .sum_valid (sum_valid)
  );

  // stages 7-8
  fp_normalize fp_normalize_i (
    .clk          (clk),
    .rstn         (rstn),
    .sum          (sum),
    .sum_valid    (sum_valid),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

// ==== logic/fp_normalize.sv ====
//----------------------------------------------------------
// fp_normalize
// stages 7-8: carry right-normalization with rounding, then
// leading-one left-normalization and result packing
//----------------------------------------------------------
`include "fp_defs.svh"

module fp_normalize import fp_pkg::*; (
  input  logic    clk,
  input  logic    rstn,
  input  fp_sum_t sum,
  input  logic    sum_valid,
  output fp_num_t result,
  output logic    result_valid
);

  // stage 7 registers
  fp_sum_t s7;
  logic    s7_valid;

  logic                 carry;
  logic                 rnd_up;
  logic [`FP_SUM_W-1:0] mag_rsh;
  logic [5:0]           lz_shift;
  logic [`FP_SUM_W-1:0] mag_lsh;

  // carry means 1x.xxx, one place right
  assign carry   = sum.mag[`FP_SUM_W-1];
  // both dropped lsb and new lsb set
  assign rnd_up  = sum.mag[1] & sum.mag[0];
  assign mag_rsh = {1'b0, sum.mag[`FP_SUM_W-1:1]} + {{(`FP_SUM_W-1){1'b0}}, rnd_up};

  // stage 7
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      s7       <= '0;
      s7_valid <= 1'b0;
    end else begin
      s7.sign  <= sum.sign;
      s7_valid <= sum_valid;
      if (carry) begin
        s7.exp <= sum.exp + 1'b1;
        s7.mag <= mag_rsh;
      end else begin
        s7.exp <= sum.exp;
        s7.mag <= sum.mag;
      end
    end
  end

  // leading one in the fraction, highest bit wins
  // zero fraction leaves the shift at zero
  always_comb begin
    lz_shift = '0;
    for (int i = 0; i < `FP_MAN_W; i++) begin
      if (s7.mag[i]) begin
        lz_shift = 6'(`FP_MAN_W - i);
      end
    end
  end

  assign mag_lsh = s7.mag << lz_shift;

  // stage 8
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result.sign  <= s7.sign;
      result_valid <= s7_valid;
      if (s7.mag[`FP_MAN_W]) begin
        // hidden position already holds the one
        result.exp <= s7.exp;
        result.man <= s7.mag[`FP_MAN_W-1:0];
      end else begin
        result.exp <= s7.exp - {{(`FP_EXP_W-6){1'b0}}, lz_shift};
        result.man <= mag_lsh[`FP_MAN_W-1:0];
      end
    end
  end

  // rounding after the right shift cannot carry out again
  a_no_carry_s7: assert property (@(posedge clk) disable iff (!rstn)
    s7_valid |-> !s7.mag[`FP_SUM_W-1]);

endmodule

// ==== logic/fp_mant_addsub.sv ====
//----------------------------------------------------------
// fp_mant_addsub
// stages 4-6: order the aligned significands, add or
// subtract them, pick the sign and take the magnitude
//----------------------------------------------------------
`include "fp_defs.svh"

module fp_mant_addsub import fp_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  fp_aligned_t aln,
  input  logic        aln_valid,
  output fp_sum_t     sum,
  output logic        sum_valid
);

  // stage 4 registers
  logic                 s4_sign_a;
  logic                 s4_sign_b;
  logic [`FP_EXP_W-1:0] s4_exp;
  logic [`FP_SIG_W-1:0] s4_op_a;
  logic [`FP_SIG_W-1:0] s4_op_b;
  logic                 s4_a_gt_b;
  logic                 s4_valid;

  // stage 5 registers
  fp_sum_t s5;
  logic    s5_neg;
  logic    s5_valid;

  logic                 sub_op;
  logic [`FP_SUM_W-1:0] add_res;
  logic [`FP_SUM_W-1:0] sub_res;
  logic                 res_sign;
  logic                 res_neg;
  logic                 res_zero;

  // stage 4
  // a negative a with a positive b swaps, so op_a is the positive one
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      s4_sign_a <= 1'b0;
      s4_sign_b <= 1'b0;
      s4_exp    <= '0;
      s4_op_a   <= '0;
      s4_op_b   <= '0;
      s4_a_gt_b <= 1'b0;
      s4_valid  <= 1'b0;
    end else begin
      s4_sign_a <= aln.sign_a;
      s4_sign_b <= aln.sign_b;
      s4_exp    <= aln.exp;
      s4_a_gt_b <= aln.sig_a > aln.sig_b;
      s4_valid  <= aln_valid;
      if (aln.sign_a && !aln.sign_b) begin
        s4_op_a <= aln.sig_b;
        s4_op_b <= aln.sig_a;
      end else begin
        s4_op_a <= aln.sig_a;
        s4_op_b <= aln.sig_b;
      end
    end
  end

  // stage 5 arithmetic
  assign sub_op  = s4_sign_a ^ s4_sign_b;
  assign add_res = {1'b0, s4_op_a} + {1'b0, s4_op_b};
  assign sub_res = {1'b0, s4_op_a} - {1'b0, s4_op_b};

  // sign of a only when a is strictly larger
  assign res_sign = s4_a_gt_b ? s4_sign_a : s4_sign_b;

  // difference went negative, the subtrahend was bigger
  assign res_neg  = sub_op & (s4_sign_a ? s4_a_gt_b : ~s4_a_gt_b);
  // x - x gives +0
  assign res_zero = sub_op & ~|sub_res;

  // stage 5
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      s5       <= '0;
      s5_neg   <= 1'b0;
      s5_valid <= 1'b0;
    end else begin
      s5.sign  <= res_zero ? 1'b0 : res_sign;
      s5.exp   <= res_zero ? '0 : s4_exp;
      s5.mag   <= sub_op ? sub_res : add_res;
      s5_neg   <= res_neg;
      s5_valid <= s4_valid;
    end
  end

  // stage 6, two's complement back to a magnitude
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sum       <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum.sign  <= s5.sign;
      sum.exp   <= s5.exp;
      sum.mag   <= s5_neg ? (~s5.mag + 1'b1) : s5.mag;
      sum_valid <= s5_valid;
    end
  end

  // a difference never needs the carry bit
  a_sub_no_carry: assert property (@(posedge clk) disable iff (!rstn)
    sum_valid && $past(sub_op, 2) |-> !sum.mag[`FP_SUM_W-1]);

endmodule

// ==== logic/fp_align.sv ====
//----------------------------------------------------------
// fp_align
// stage 3: shift the smaller-exponent significand onto the
// larger exponent and round it
//----------------------------------------------------------
`include "fp_defs.svh"

module fp_align import fp_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  fp_unp_t     unp,
  input  logic        unp_valid,
  output fp_aligned_t aln,
  output logic        aln_valid
);

  // shift right over a 52 bit extension, then round
  // guard set plus any of round, sticky or kept lsb
  function automatic logic [`FP_SIG_W-1:0] align_round(
    input logic [`FP_SIG_W-1:0] sig,
    input logic [`FP_EXP_W:0]   amt
  );
    logic [`FP_SIG_W+`FP_MAN_W-1:0] ext;
    logic                           lsb;
    logic                           guard;
    logic                           rnd;
    logic                           sticky;
    logic                           round_up;
    ext      = {sig, {`FP_MAN_W{1'b0}}} >> amt;
    lsb      = ext[`FP_MAN_W];
    guard    = ext[`FP_MAN_W-1];
    rnd      = ext[`FP_MAN_W-2];
    sticky   = |ext[`FP_MAN_W-3:0];
    round_up = guard & (rnd | sticky | lsb);
    // kept part has a clear top bit once shifted, no wrap
    return ext[`FP_SIG_W+`FP_MAN_W-1:`FP_MAN_W] + {{(`FP_SIG_W-1){1'b0}}, round_up};
  endfunction

  logic                 a_larger;
  logic [`FP_EXP_W:0]   shift_a;
  logic [`FP_EXP_W:0]   shift_b;
  logic [`FP_SIG_W-1:0] sig_a_al;
  logic [`FP_SIG_W-1:0] sig_b_al;

  // non-negative difference keeps a as the reference
  assign a_larger = ~unp.exp_diff[`FP_EXP_W];

  // only one of these is used per operand pair
  assign shift_b = unp.exp_diff;
  assign shift_a = -unp.exp_diff;

  assign sig_a_al = align_round(unp.sig_a, shift_a);
  assign sig_b_al = align_round(unp.sig_b, shift_b);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aln       <= '0;
      aln_valid <= 1'b0;
    end else begin
      aln.sign_a <= unp.sign_a;
      aln.sign_b <= unp.sign_b;
      aln_valid  <= unp_valid;
      if (a_larger) begin
        aln.exp   <= unp.exp_a;
        aln.sig_a <= unp.sig_a;
        aln.sig_b <= sig_b_al;
      end else begin
        aln.exp   <= unp.exp_b;
        aln.sig_a <= sig_a_al;
        aln.sig_b <= unp.sig_b;
      end
    end
  end

  // common exponent is the larger of the two stage 2 fields
  a_common_exp: assert property (@(posedge clk) disable iff (!rstn)
    aln_valid |-> aln.exp == (($past(unp.exp_a) >= $past(unp.exp_b)) ?
                              $past(unp.exp_a) : $past(unp.exp_b)));

endmodule

// ==== logic/fp_unpack.sv ====
//----------------------------------------------------------
// fp_unpack
// stages 1-2: operand capture, hidden bit insertion and
// signed exponent difference
//----------------------------------------------------------
`include "fp_defs.svh"

module fp_unpack import fp_pkg::*; (
  input  logic    clk,
  input  logic    rstn,
  input  fp_num_t num_a,
  input  fp_num_t num_b,
  input  logic    in_valid,
  output fp_unp_t unp,
  output logic    unp_valid
);

  // stage 1 operand registers
  fp_num_t s1_a;
  fp_num_t s1_b;
  logic    s1_valid;

  logic                      hid_a;
  logic                      hid_b;
  logic signed [`FP_EXP_W:0] exp_diff;

  // zero exponent field means no hidden one
  assign hid_a = |s1_a.exp;
  assign hid_b = |s1_b.exp;

  // zero extend both fields, result may go negative
  assign exp_diff = $signed({1'b0, s1_a.exp}) - $signed({1'b0, s1_b.exp});

  // stage 1
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      s1_a     <= '0;
      s1_b     <= '0;
      s1_valid <= 1'b0;
    end else begin
      s1_a     <= num_a;
      s1_b     <= num_b;
      s1_valid <= in_valid;
    end
  end

  // stage 2
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      unp       <= '0;
      unp_valid <= 1'b0;
    end else begin
      unp.sign_a   <= s1_a.sign;
      unp.sign_b   <= s1_b.sign;
      unp.exp_a    <= s1_a.exp;
      unp.exp_b    <= s1_b.exp;
      unp.sig_a    <= {hid_a, s1_a.man};
      unp.sig_b    <= {hid_b, s1_b.man};
      unp.exp_diff <= exp_diff;
      unp_valid    <= s1_valid;
    end
  end

endmodule

// ==== logic/fp_pkg.sv ====
//----------------------------------------------------------
// fp_pkg
// operand layout and the payload carried between the
// stage blocks of the double precision adder
//----------------------------------------------------------
`include "fp_defs.svh"

package fp_pkg;

  // one ieee-754 double, msb first
  typedef struct packed {
    logic                 sign;
    logic [`FP_EXP_W-1:0] exp;
    logic [`FP_MAN_W-1:0] man;
  } fp_num_t;

  // operand pair after hidden bit insertion
  // exp_diff is exp_a - exp_b, one bit wider than the field
  typedef struct packed {
    logic                        sign_a;
    logic                        sign_b;
    logic [`FP_EXP_W-1:0]        exp_a;
    logic [`FP_EXP_W-1:0]        exp_b;
    logic [`FP_SIG_W-1:0]        sig_a;
    logic [`FP_SIG_W-1:0]        sig_b;
    logic signed [`FP_EXP_W:0]   exp_diff;
  } fp_unp_t;

  // pair on a common exponent
  // smaller operand already shifted and rounded
  typedef struct packed {
    logic                 sign_a;
    logic                 sign_b;
    logic [`FP_EXP_W-1:0] exp;
    logic [`FP_SIG_W-1:0] sig_a;
    logic [`FP_SIG_W-1:0] sig_b;
  } fp_aligned_t;

  // signed magnitude result, not yet normalized
  // mag keeps the adder carry in its top bit
  typedef struct packed {
    logic                 sign;
    logic [`FP_EXP_W-1:0] exp;
    logic [`FP_SUM_W-1:0] mag;
  } fp_sum_t;

endpackage

// ==== logic/fp_defs.svh ====
//----------------------------------------------------------
// double precision adder constants
// field widths of ieee-754 binary64, exponent bias and the
// number of register stages through the adder
//----------------------------------------------------------
`ifndef FP_DEFS_SVH
`define FP_DEFS_SVH

// full operand width
`define FP_WIDTH      64

// exponent field
`define FP_EXP_W      11

// stored fraction, no hidden bit
`define FP_MAN_W      52

// fraction plus hidden bit
`define FP_SIG_W      53

// significand sum with one carry bit on top
`define FP_SUM_W      54

// exponent bias of binary64
`define FP_BIAS       1023

// operand capture to result register
`define FP_PIPE_DEPTH 8

`endif
